/* project.f */
+incdir+.
mips_pkg.sv
mips_ctrl_if.sv
mips_alu.sv
mips_regfile.sv
mips_decoder.sv
mips_pc_unit.sv
mips_datapath.sv
mips_cpu.sv
mips_checker.sv
tb_mips_cpu.sv

/* Bender.yml */
package:
  name: mips_cpu

sources:
  - include_dirs:
      - .
    files:
      - mips_pkg.sv
      - mips_ctrl_if.sv
      - mips_alu.sv
      - mips_regfile.sv
      - mips_decoder.sv
      - mips_pc_unit.sv
      - mips_datapath.sv
      - mips_cpu.sv
  - target: test
    include_dirs:
      - .
    files:
      - mips_checker.sv
      - tb_mips_cpu.sv

/* tb_mips_cpu.sv */
`timescale 1ns/1ps
`include "mips_defines.svh"

module tb_mips_cpu;

  // Funct codes of the R-type cases in test_alu in case order
  localparam int alu_functs [14] = '{'h21, 'h23, 'h24, 'h25, 'h26, 'h27, 'h2a, 'h2b,
                                     'h00, 'h02, 'h03, 'h04, 'h06, 'h07};

  logic            clk = 1'b0;
  logic            reset;
  logic            clk_enable;
  logic            active;
  mips_pkg::word_t instr_address;
  mips_pkg::word_t instr_readdata;
  mips_pkg::word_t data_address;
  mips_pkg::word_t data_writedata;
  logic            data_write;
  mips_pkg::word_t data_readdata;
  mips_pkg::word_t register_v0;

  mips_pkg::word_t imem [256]; // 1 KB of word addressed program memory
  mips_pkg::word_t dmem [256];
  integer          seed;
  int              checks;
  int              errors;
  int              tests;

  always #50 clk = ~clk; // 100 ns period

  // Both memories answer within the same cycle
  assign instr_readdata = imem[instr_address[9:2]];
  assign data_readdata  = dmem[data_address[9:2]];

  always @(posedge clk) begin
    if (data_write && clk_enable) begin
      dmem[data_address[9:2]] <= data_writedata; // Store lands on the retiring edge
    end
  end

  mips_cpu i_dut (
    .clk            (clk),
    .reset          (reset),
    .clk_enable     (clk_enable),
    .active         (active),
    .instr_address  (instr_address),
    .instr_readdata (instr_readdata),
    .data_address   (data_address),
    .data_writedata (data_writedata),
    .data_write     (data_write),
    .data_readdata  (data_readdata),
    .register_v0    (register_v0)
  );

  function automatic mips_pkg::word_t rtype(int rs, int rt, int rd, int sh, int fn);
    return {6'h00, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn[5:0]};
  endfunction

  function automatic mips_pkg::word_t itype(int op, int rs, int rt, logic [15:0] imm);
    return {op[5:0], rs[4:0], rt[4:0], imm};
  endfunction

  function automatic mips_pkg::word_t jtype(int op, mips_pkg::word_t target);
    return {op[5:0], target[27:2]}; // Word index inside the current region
  endfunction

  task automatic check_word(input string name, input mips_pkg::word_t got,
                            input mips_pkg::word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0d ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0d ns: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  // Core is stopped first so that a half written program never retires
  task automatic clear_memories();
    @(posedge clk);
    clk_enable <= 1'b0;
    @(negedge clk);
    for (int i = 0; i < 256; i++) begin
      imem[i] = 32'h0000_0000; // sll $0,$0,0 does nothing
      dmem[i] = 32'h0000_0000;
    end
  endtask

  task automatic reset_core(input logic enable_after);
    @(posedge clk);
    reset      <= 1'b1;
    clk_enable <= 1'b0;
    repeat (5) @(posedge clk);
    reset      <= 1'b0;
    clk_enable <= enable_after;
    @(negedge clk); // Outputs are settled mid cycle
  endtask

  task automatic set_enable(input logic value);
    @(posedge clk);
    clk_enable <= value;
    @(negedge clk);
  endtask

  task automatic run_to_halt(input string name, input mips_pkg::word_t halt_addr);
    int n;
    n = 0;
    while (instr_address !== halt_addr && n < 200) begin
      @(negedge clk);
      n++;
    end
    if (instr_address !== halt_addr) begin
      errors++;
      $display("%s: fetch never reached the halt address %h within 200 cycles", name, halt_addr);
    end
  endtask

  task automatic finish_test(input string name, input int err0);
    tests++;
    $display("test %s: %s", name, (errors == err0) ? "pass" : "fail");
  endtask

  task automatic test_alu();
    mips_pkg::word_t a;
    mips_pkg::word_t b;
    mips_pkg::word_t rnd;
    mips_pkg::word_t ins;
    mips_pkg::word_t exp;
    logic [4:0]      sh;
    logic [63:0]     sra_wide;
    logic [63:0]     srav_wide;
    logic            shift_imm;
    int              err0;
    err0 = errors;
    for (int k = 0; k < 15; k++) begin
      a         = $random(seed);
      b         = $random(seed);
      rnd       = $random(seed);
      sh        = rnd[4:0];
      sra_wide  = {{32{b[31]}}, b} >> sh; // Sign copies shift in from the top
      srav_wide = {{32{b[31]}}, b} >> a[4:0];
      shift_imm = (k >= 8) && (k <= 10);
      case (k)
        0:  exp = a + b;
        1:  exp = a - b;
        2:  exp = a & b;
        3:  exp = a | b;
        4:  exp = a ^ b;
        5:  exp = ~(a | b);
        6:  exp = {31'b0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)}; // Signed via offset
        7:  exp = {31'b0, a < b};
        8:  exp = b << sh;
        9:  exp = b >> sh;
        10: exp = sra_wide[31:0];
        11: exp = b << a[4:0];
        12: exp = b >> a[4:0];
        13: exp = srav_wide[31:0];
        default: exp = {b[15:0], 16'h0000};
      endcase
      if (k == 14) begin
        ins = itype('h0f, 0, 2, b[15:0]); // lui $2
      end else begin
        ins = rtype(shift_imm ? 0 : 8, 9, 2, shift_imm ? int'(sh) : 0, alu_functs[k]);
      end
      clear_memories();
      imem[0] = itype('h0f, 0, 8, a[31:16]); // $8 = a
      imem[1] = itype('h0d, 8, 8, a[15:0]);
      imem[2] = itype('h0f, 0, 9, b[31:16]); // $9 = b
      imem[3] = itype('h0d, 9, 9, b[15:0]);
      imem[4] = ins;
      reset_core(1'b1);
      run_to_halt("alu", `MIPS_RESET_VECTOR + 32'd20);
      check_word($sformatf("register_v0 (alu case %0d)", k), register_v0, exp);
    end
    finish_test("alu", err0);
  endtask

  task automatic test_memory();
    mips_pkg::word_t w;
    mips_pkg::word_t rnd;
    logic [1:0]      k;
    logic            h;
    logic [7:0]      bv;
    logic [15:0]     hv;
    int              err0;
    err0 = errors;
    w   = $random(seed);
    w   = w | 32'h8080_8080; // Every byte and half has its sign bit set
    rnd = $random(seed);
    k   = rnd[1:0];          // Byte offset for lb and lbu
    h   = rnd[2];            // Halfword offset for lh and lhu
    bv  = w[8*k +: 8];       // Lane 0 is the lowest address
    hv  = w[16*h +: 16];
    clear_memories();
    imem[0]  = itype('h0f, 0, 8, w[31:16]);
    imem[1]  = itype('h0d, 8, 8, w[15:0]);
    imem[2]  = itype('h09, 0, 9, 16'h0040); // Base address
    imem[3]  = itype('h2b, 9, 8, 16'h0000);
    imem[4]  = itype('h23, 9, 10, 16'h0000);
    imem[5]  = itype('h20, 9, 11, {14'b0, k});
    imem[6]  = itype('h24, 9, 12, {14'b0, k});
    imem[7]  = itype('h21, 9, 13, {14'b0, h, 1'b0});
    imem[8]  = itype('h25, 9, 14, {14'b0, h, 1'b0});
    for (int i = 0; i < 5; i++) begin
      imem[9 + i] = itype('h2b, 9, 10 + i, 16'(4 * (i + 1))); // Each loaded value to its own word
    end
    imem[14] = rtype(13, 0, 2, 0, 'h21); // v0 takes the lh result
    reset_core(1'b1);
    run_to_halt("memory", `MIPS_RESET_VECTOR + 32'd60);
    check_word("dmem[0x40]", dmem[16], w);
    check_word("dmem[0x44]", dmem[17], w);
    check_word("dmem[0x48]", dmem[18], {{24{bv[7]}}, bv});
    check_word("dmem[0x4c]", dmem[19], {24'b0, bv});
    check_word("dmem[0x50]", dmem[20], {{16{hv[15]}}, hv});
    check_word("dmem[0x54]", dmem[21], {16'b0, hv});
    check_word("register_v0", register_v0, {{16{hv[15]}}, hv});
    finish_test("memory", err0);
  endtask

  task automatic test_branches();
    mips_pkg::word_t exp;
    logic            is_bne;
    logic            equal;
    logic            taken;
    int              err0;
    err0 = errors;
    for (int c = 0; c < 4; c++) begin
      is_bne = c[1];
      equal  = c[0];
      taken  = is_bne ? !equal : equal;
      exp    = taken ? 32'h0000_0101 : 32'h0000_0111; // Delay slot adds 1 either way
      clear_memories();
      imem[0] = itype('h09, 0, 8, 16'd5);
      imem[1] = itype('h09, 0, 9, equal ? 16'd5 : 16'd7);
      imem[2] = itype('h09, 0, 2, 16'd0);
      imem[3] = itype(is_bne ? 'h05 : 'h04, 8, 9, 16'd2); // Target 0x0c + 4 + 8
      imem[4] = itype('h09, 2, 2, 16'h0001);
      imem[5] = itype('h09, 2, 2, 16'h0010);
      imem[6] = itype('h09, 2, 2, 16'h0100);
      reset_core(1'b1);
      run_to_halt("branch", `MIPS_RESET_VECTOR + 32'd28);
      check_word($sformatf("register_v0 (%s, equal %b)", is_bne ? "bne" : "beq", equal),
                 register_v0, exp);
    end
    finish_test("branch", err0);
  endtask

  task automatic test_jumps();
    int err0;
    err0 = errors;
    clear_memories();
    imem[0]  = itype('h09, 0, 2, 16'h0000);
    imem[1]  = jtype('h03, 32'd40);          // jal from 0x04
    imem[2]  = itype('h09, 2, 2, 16'h0001);
    imem[3]  = itype('h2b, 0, 31, 16'h0040); // Return lands here
    imem[4]  = itype('h09, 0, 10, 16'd56);
    imem[5]  = rtype(10, 0, 31, 0, 'h09);    // jalr from 0x14
    imem[6]  = itype('h09, 2, 2, 16'h0100);
    imem[7]  = itype('h2b, 0, 31, 16'h0044);
    imem[8]  = jtype('h02, 32'd72);          // Out to the halt address
    imem[9]  = itype('h09, 0, 0, 16'h0055);  // Delay slot of j aims a write at $0
    imem[10] = itype('h09, 2, 2, 16'h0010);
    imem[11] = rtype(31, 0, 0, 0, 'h08);
    imem[12] = itype('h09, 2, 2, 16'h0020);
    imem[13] = itype('h09, 2, 2, 16'h1000);  // Never reached
    imem[14] = itype('h09, 2, 2, 16'h0200);
    imem[15] = rtype(31, 0, 0, 0, 'h08);
    imem[16] = itype('h09, 2, 2, 16'h0400);
    imem[17] = itype('h09, 2, 2, 16'h1000);
    reset_core(1'b1);
    run_to_halt("jump", `MIPS_RESET_VECTOR + 32'd72);
    check_word("dmem[0x40]", dmem[16], 32'd4 + 32'd8);
    check_word("dmem[0x44]", dmem[17], 32'd20 + 32'd8);
    check_word("register_v0", register_v0, 32'h0000_0731);
    finish_test("jump", err0);
  endtask

  task automatic test_enable();
    int err0;
    err0 = errors;
    clear_memories();
    for (int i = 0; i < 16; i++) begin
      imem[i] = itype('h09, 2, 2, 16'h0001); // Every retired instruction bumps v0
    end
    reset_core(1'b0);
    check_word("instr_address", instr_address, `MIPS_RESET_VECTOR);
    check_bit("active", active, 1'b0);
    repeat (3) @(negedge clk);
    check_word("instr_address", instr_address, `MIPS_RESET_VECTOR);
    check_word("register_v0", register_v0, 32'd0);
    check_bit("active", active, 1'b0);
    set_enable(1'b1);
    check_bit("active", active, 1'b0); // The enable is sampled from the next edge
    @(negedge clk);
    check_bit("active", active, 1'b1);
    check_word("instr_address", instr_address, `MIPS_RESET_VECTOR + 32'd4);
    check_word("register_v0", register_v0, 32'd1);
    repeat (2) @(negedge clk);
    set_enable(1'b0); // That edge still retires a fourth instruction
    check_word("instr_address", instr_address, `MIPS_RESET_VECTOR + 32'd16);
    check_word("register_v0", register_v0, 32'd4);
    repeat (3) @(negedge clk);
    check_word("instr_address", instr_address, `MIPS_RESET_VECTOR + 32'd16);
    check_word("register_v0", register_v0, 32'd4);
    finish_test("enable", err0);
  endtask

  initial begin
    seed       = 62;
    checks     = 0;
    errors     = 0;
    tests      = 0;
    reset      = 1'b1;
    clk_enable = 1'b0;
    for (int i = 0; i < 256; i++) begin
      imem[i] = 32'h0000_0000;
      dmem[i] = 32'h0000_0000;
    end
    test_enable();
    test_alu();
    test_memory();
    test_branches();
    test_jumps();
    if (i_dut.i_checker.fail_count != 0) begin
      $display("bound checker saw %0d assertion failures", i_dut.i_checker.fail_count);
      errors = errors + i_dut.i_checker.fail_count;
    end
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* mips_checker.sv */
`timescale 1ns/1ps
`include "mips_defines.svh"

module mips_checker (
  input logic            clk,
  input logic            reset,
  input logic            clk_enable,
  input logic            active,
  input logic            data_write,
  input mips_pkg::word_t instr_address,
  input mips_pkg::word_t regs [`MIPS_REG_COUNT]
);

  int fail_count = 0; // Number of failed assertions so far

  // No store may reach memory while the core is held in reset
  a_reset_no_write: assert property (@(posedge clk) reset |-> !data_write)
    else begin
      fail_count++;
      $error("data_write high during reset");
    end

  a_reset_inactive: assert property (@(posedge clk) reset |=> !active)
    else begin
      fail_count++;
      $error("active high after a reset edge");
    end

  // A disabled edge must leave the fetch address alone
  a_pc_holds: assert property (@(posedge clk) (!reset && !clk_enable) |=> $stable(instr_address))
    else begin
      fail_count++;
      $error("instr_address moved while clk_enable was low");
    end

  a_zero_reg: assert property (@(posedge clk) !reset |-> (regs[0] == '0)) // $0 reads as zero
    else begin
      fail_count++;
      $error("register zero holds a nonzero value");
    end

endmodule

bind mips_cpu mips_checker i_checker (
  .clk           (clk),
  .reset         (reset),
  .clk_enable    (clk_enable),
  .active        (active),
  .data_write    (data_write),
  .instr_address (instr_address),
  .regs          (i_datapath.i_regfile.regs)
);

/* mips_cpu.sv */
`timescale 1ns/1ps

module mips_cpu (
  input  logic            clk,
  input  logic            reset,
  input  logic            clk_enable,
  output logic            active,
  output mips_pkg::word_t instr_address,
  input  mips_pkg::word_t instr_readdata,
  output mips_pkg::word_t data_address,
  output mips_pkg::word_t data_writedata,
  output logic            data_write,
  input  mips_pkg::word_t data_readdata,
  output mips_pkg::word_t register_v0
);

  logic            zero;       // ALU zero flag for the branch decision
  mips_pkg::word_t rs_value;   // Jump register target
  mips_pkg::word_t link_value; // Return address for jal and jalr

  mips_ctrl_if ctrl ();

  mips_decoder i_decoder (
    .instr (instr_readdata),
    .ctrl  (ctrl.decoder)
  );

  // Fetch address is the PC itself
  mips_pc_unit i_pc_unit (
    .clk        (clk),
    .reset      (reset),
    .clk_enable (clk_enable),
    .ctrl       (ctrl.datapath),
    .instr      (instr_readdata),
    .zero       (zero),
    .rs_value   (rs_value),
    .pc         (instr_address),
    .link_value (link_value),
    .active     (active)
  );

  mips_datapath i_datapath (
    .clk            (clk),
    .reset          (reset),
    .clk_enable     (clk_enable),
    .ctrl           (ctrl.datapath),
    .instr          (instr_readdata),
    .link_value     (link_value),
    .zero           (zero),
    .rs_value       (rs_value),
    .data_address   (data_address),
    .data_writedata (data_writedata),
    .data_write     (data_write),
    .data_readdata  (data_readdata),
    .register_v0    (register_v0)
  );

endmodule

/* mips_datapath.sv */
`timescale 1ns/1ps

module mips_datapath (
  input  logic            clk,
  input  logic            reset,
  input  logic            clk_enable,
  mips_ctrl_if.datapath   ctrl,
  input  mips_pkg::word_t instr,
  input  mips_pkg::word_t link_value,
  output logic            zero,
  output mips_pkg::word_t rs_value,
  output mips_pkg::word_t data_address,
  output mips_pkg::word_t data_writedata,
  output logic            data_write,
  input  mips_pkg::word_t data_readdata,
  output mips_pkg::word_t register_v0
);

  mips_pkg::reg_addr_t rs_addr;
  mips_pkg::reg_addr_t rt_addr;
  mips_pkg::reg_addr_t rd_addr;
  mips_pkg::reg_addr_t wa;
  mips_pkg::imm_t      imm;
  mips_pkg::word_t     ext_imm;
  mips_pkg::word_t     rt_value;
  mips_pkg::word_t     alu_b;
  mips_pkg::word_t     alu_y;
  mips_pkg::word_t     load_value;
  mips_pkg::word_t     wb_value;
  logic [7:0]          byte_val;
  logic [15:0]         half_val;

  assign rs_addr = instr[25:21];
  assign rt_addr = instr[20:16];
  assign rd_addr = instr[15:11];
  assign imm     = instr[15:0];

  assign ext_imm = ctrl.imm_zero_ext ? {16'b0, imm} : {{16{imm[15]}}, imm};
  assign alu_b   = ctrl.alu_src_imm ? ext_imm : rt_value;

  // Link wins over the R-type rd field so jalr also ends up in $31
  assign wa = ctrl.link ? 5'd31 : (ctrl.reg_dst_rd ? rd_addr : rt_addr);

  // Byte lanes are little-endian with lane 0 at the lowest address
  always_comb begin
    case (alu_y[1:0])
      2'd0:    byte_val = data_readdata[7:0];
      2'd1:    byte_val = data_readdata[15:8];
      2'd2:    byte_val = data_readdata[23:16];
      default: byte_val = data_readdata[31:24];
    endcase
    half_val = alu_y[1] ? data_readdata[31:16] : data_readdata[15:0];
    case (ctrl.load_kind)
      mips_pkg::ld_byte_s: load_value = {{24{byte_val[7]}}, byte_val};
      mips_pkg::ld_byte_u: load_value = {24'b0, byte_val};
      mips_pkg::ld_half_s: load_value = {{16{half_val[15]}}, half_val};
      mips_pkg::ld_half_u: load_value = {16'b0, half_val};
      default:             load_value = data_readdata;
    endcase
  end

  assign wb_value = ctrl.link ? link_value : (ctrl.mem_to_reg ? load_value : alu_y);

  assign data_address   = alu_y; // Effective address of loads and stores
  assign data_writedata = rt_value;
  assign data_write     = ctrl.mem_write & clk_enable; // Store commits only on a retiring edge

  mips_regfile i_regfile (
    .clk        (clk),
    .reset      (reset),
    .clk_enable (clk_enable),
    .ra1        (rs_addr),
    .ra2        (rt_addr),
    .rd1        (rs_value),
    .rd2        (rt_value),
    .we         (ctrl.reg_write),
    .wa         (wa),
    .wd         (wb_value),
    .v0         (register_v0)
  );

  mips_alu i_alu (
    .op    (ctrl.alu_op),
    .a     (rs_value),
    .b     (alu_b),
    .shamt (instr[10:6]),
    .y     (alu_y),
    .zero  (zero)
  );

endmodule

/* mips_pc_unit.sv */
`timescale 1ns/1ps
`include "mips_defines.svh"

module mips_pc_unit (
  input  logic            clk,
  input  logic            reset,
  input  logic            clk_enable,
  mips_ctrl_if.datapath   ctrl,
  input  mips_pkg::word_t instr,
  input  logic            zero,
  input  mips_pkg::word_t rs_value,
  output mips_pkg::word_t pc,
  output mips_pkg::word_t link_value,
  output logic            active
);

  mips_pkg::word_t next_addr;     // Delay slot register, address fetched after this one
  mips_pkg::word_t next_addr_d;
  mips_pkg::word_t branch_target;
  mips_pkg::word_t jump_target;
  mips_pkg::imm_t  offset;
  logic            taken;

  assign offset = instr[15:0];

  // Word offset is relative to the delay slot address
  assign branch_target = pc + 32'd4 + {{14{offset[15]}}, offset, 2'b00};
  assign jump_target   = {pc[31:28], instr[25:0], 2'b00}; // Stays inside the 256 MB region
  assign taken         = ctrl.branch & (zero ^ ctrl.branch_ne);
  assign link_value    = pc + 32'd8; // Return skips over the delay slot

  // The target lands one instruction late, so the delay slot always runs
  always_comb begin
    if (ctrl.jump_reg) begin
      next_addr_d = rs_value;
    end else if (ctrl.jump) begin
      next_addr_d = jump_target;
    end else if (taken) begin
      next_addr_d = branch_target;
    end else begin
      next_addr_d = next_addr + 32'd4; // Sequential flow continues after the held address
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc        <= `MIPS_RESET_VECTOR;
      next_addr <= `MIPS_RESET_VECTOR + 32'd4;
      active    <= 1'b0;
    end else if (clk_enable) begin
      pc        <= next_addr;
      next_addr <= next_addr_d;
      active    <= 1'b1; // First retired instruction marks the core as running
    end
  end

endmodule

/* mips_decoder.sv */
`timescale 1ns/1ps

module mips_decoder (
  input  mips_pkg::word_t instr,
  mips_ctrl_if.decoder    ctrl
);

  logic [5:0] opcode;
  logic [5:0] funct;

  assign opcode = instr[31:26];
  assign funct  = instr[5:0]; // Only meaningful for the SPECIAL opcode

  always_comb begin
    // Defaults describe an instruction that changes no state
    ctrl.alu_op       = mips_pkg::alu_add;
    ctrl.alu_src_imm  = 1'b0;
    ctrl.imm_zero_ext = 1'b0;
    ctrl.reg_dst_rd   = 1'b0;
    ctrl.link         = 1'b0;
    ctrl.reg_write    = 1'b0;
    ctrl.mem_to_reg   = 1'b0;
    ctrl.load_kind    = mips_pkg::ld_word;
    ctrl.mem_write    = 1'b0;
    ctrl.branch       = 1'b0;
    ctrl.branch_ne    = 1'b0;
    ctrl.jump         = 1'b0;
    ctrl.jump_reg     = 1'b0;

    case (opcode)
      6'h00: begin // SPECIAL, the funct field picks the operation
        ctrl.reg_dst_rd = 1'b1;
        ctrl.reg_write  = 1'b1;
        case (funct)
          6'h00: ctrl.alu_op = mips_pkg::alu_sll;
          6'h02: ctrl.alu_op = mips_pkg::alu_srl;
          6'h03: ctrl.alu_op = mips_pkg::alu_sra;
          6'h04: ctrl.alu_op = mips_pkg::alu_sllv;
          6'h06: ctrl.alu_op = mips_pkg::alu_srlv;
          6'h07: ctrl.alu_op = mips_pkg::alu_srav;
          6'h08: begin // jr writes no register
            ctrl.jump_reg  = 1'b1;
            ctrl.reg_write = 1'b0;
          end
          6'h09: begin // jalr links into $31
            ctrl.jump_reg = 1'b1;
            ctrl.link     = 1'b1;
          end
          6'h20, 6'h21: ctrl.alu_op = mips_pkg::alu_add; // No overflow trap, add acts as addu
          6'h22, 6'h23: ctrl.alu_op = mips_pkg::alu_sub;
          6'h24: ctrl.alu_op = mips_pkg::alu_and;
          6'h25: ctrl.alu_op = mips_pkg::alu_or;
          6'h26: ctrl.alu_op = mips_pkg::alu_xor;
          6'h27: ctrl.alu_op = mips_pkg::alu_nor;
          6'h2A: ctrl.alu_op = mips_pkg::alu_slt;
          6'h2B: ctrl.alu_op = mips_pkg::alu_sltu;
          default: ctrl.reg_write = 1'b0; // Unknown funct leaves the registers alone
        endcase
      end
      6'h02: ctrl.jump = 1'b1; // j
      6'h03: begin // jal
        ctrl.jump      = 1'b1;
        ctrl.link      = 1'b1;
        ctrl.reg_write = 1'b1;
      end
      6'h04, 6'h05: begin // beq and bne compare through a subtraction
        ctrl.alu_op    = mips_pkg::alu_sub;
        ctrl.branch    = 1'b1;
        ctrl.branch_ne = opcode[0];
      end
      6'h09, 6'h0A, 6'h0C, 6'h0D, 6'h0E, 6'h0F: begin // Immediate ALU forms
        ctrl.alu_src_imm  = 1'b1;
        ctrl.reg_write    = 1'b1;
        ctrl.imm_zero_ext = opcode[2]; // andi, ori, xori and lui
        case (opcode[2:0])
          3'b010:  ctrl.alu_op = mips_pkg::alu_slt;
          3'b100:  ctrl.alu_op = mips_pkg::alu_and;
          3'b101:  ctrl.alu_op = mips_pkg::alu_or;
          3'b110:  ctrl.alu_op = mips_pkg::alu_xor;
          3'b111:  ctrl.alu_op = mips_pkg::alu_lui;
          default: ctrl.alu_op = mips_pkg::alu_add; // addiu
        endcase
      end
      6'h20, 6'h21, 6'h23, 6'h24, 6'h25: begin // Loads, address is rs plus offset
        ctrl.alu_src_imm = 1'b1;
        ctrl.reg_write   = 1'b1;
        ctrl.mem_to_reg  = 1'b1;
        case (opcode[2:0])
          3'b000:  ctrl.load_kind = mips_pkg::ld_byte_s;
          3'b001:  ctrl.load_kind = mips_pkg::ld_half_s;
          3'b100:  ctrl.load_kind = mips_pkg::ld_byte_u;
          3'b101:  ctrl.load_kind = mips_pkg::ld_half_u;
          default: ctrl.load_kind = mips_pkg::ld_word;
        endcase
      end
      6'h2B: begin // sw
        ctrl.alu_src_imm = 1'b1;
        ctrl.mem_write   = 1'b1;
      end
      default: ; // Unknown opcode behaves as a no-op
    endcase
  end

endmodule

/* mips_regfile.sv */
`timescale 1ns/1ps
`include "mips_defines.svh"

module mips_regfile (
  input  logic                clk,
  input  logic                reset,
  input  logic                clk_enable,
  input  mips_pkg::reg_addr_t ra1,
  input  mips_pkg::reg_addr_t ra2,
  output mips_pkg::word_t     rd1,
  output mips_pkg::word_t     rd2,
  input  logic                we,
  input  mips_pkg::reg_addr_t wa,
  input  mips_pkg::word_t     wd,
  output mips_pkg::word_t     v0
);

  mips_pkg::word_t regs [`MIPS_REG_COUNT];

  // Reads are asynchronous so an instruction sees its operands in the same cycle
  assign rd1 = regs[ra1];
  assign rd2 = regs[ra2];
  assign v0  = regs[2]; // $v0 holds the function result by convention

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `MIPS_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (clk_enable && we && (wa != '0)) begin // $0 is never written
      regs[wa] <= wd;
    end
  end

endmodule

/* mips_alu.sv */
`timescale 1ns/1ps

module mips_alu (
  input  mips_pkg::alu_op_t op,
  input  mips_pkg::word_t   a,
  input  mips_pkg::word_t   b,
  input  logic [4:0]        shamt,
  output mips_pkg::word_t   y,
  output logic              zero
);

  logic [4:0] var_amount;

  // Variable shifts use rs as the amount and rt as the value
  assign var_amount = a[4:0];

  always_comb begin
    case (op)
      mips_pkg::alu_add:  y = a + b;
      mips_pkg::alu_sub:  y = a - b; // Also the compare for beq and bne
      mips_pkg::alu_and:  y = a & b;
      mips_pkg::alu_or:   y = a | b;
      mips_pkg::alu_xor:  y = a ^ b;
      mips_pkg::alu_nor:  y = ~(a | b);
      mips_pkg::alu_slt:  y = {31'b0, ($signed(a) < $signed(b))};
      mips_pkg::alu_sltu: y = {31'b0, (a < b)};
      // Fixed shifts take the amount from the shamt field
      mips_pkg::alu_sll:  y = b << shamt;
      mips_pkg::alu_srl:  y = b >> shamt;
      mips_pkg::alu_sra:  y = $signed(b) >>> shamt;
      mips_pkg::alu_sllv: y = b << var_amount;
      mips_pkg::alu_srlv: y = b >> var_amount;
      mips_pkg::alu_srav: y = $signed(b) >>> var_amount;
      mips_pkg::alu_lui:  y = {b[15:0], 16'b0}; // Immediate into the upper half
      default:            y = '0;
    endcase
  end

  assign zero = (y == '0);

endmodule

/* mips_ctrl_if.sv */
`timescale 1ns/1ps

interface mips_ctrl_if;
  mips_pkg::alu_op_t    alu_op;       // Operation the ALU performs
  logic                 alu_src_imm;  // Second ALU operand comes from the immediate
  logic                 imm_zero_ext; // Logic immediates are zero extended
  logic                 reg_dst_rd;   // R-type writes rd instead of rt
  logic                 link;         // Write the link address into $31
  logic                 reg_write;
  logic                 mem_to_reg;   // Write back the loaded value
  mips_pkg::load_kind_t load_kind;
  logic                 mem_write;
  logic                 branch;       // beq or bne
  logic                 branch_ne;    // Inverts the zero test for bne
  logic                 jump;         // j and jal
  logic                 jump_reg;     // jr and jalr

  // The decoder produces every steering signal
  modport decoder (output alu_op, alu_src_imm, imm_zero_ext, reg_dst_rd, link, reg_write,
                   mem_to_reg, load_kind, mem_write, branch, branch_ne, jump, jump_reg);

  // The datapath and the PC unit only consume them
  modport datapath (input alu_op, alu_src_imm, imm_zero_ext, reg_dst_rd, link, reg_write,
                    mem_to_reg, load_kind, mem_write, branch, branch_ne, jump, jump_reg);
endinterface

/* mips_pkg.sv */
package mips_pkg;

  typedef logic [31:0] word_t;    // Data word and byte address
  typedef logic [4:0]  reg_addr_t; // Index into the register file
  typedef logic [15:0] imm_t;     // Immediate field of I-type instructions

  // One code per ALU operation, shared by the decoder and the ALU
  typedef enum logic [4:0] {
    alu_add  = 5'd0,
    alu_sub  = 5'd1,
    alu_and  = 5'd2,
    alu_or   = 5'd3,
    alu_xor  = 5'd4,
    alu_nor  = 5'd5,
    alu_slt  = 5'd6,
    alu_sltu = 5'd7,
    alu_sll  = 5'd8,
    alu_srl  = 5'd9,
    alu_sra  = 5'd10,
    alu_sllv = 5'd11,
    alu_srlv = 5'd12,
    alu_srav = 5'd13,
    alu_lui  = 5'd14
  } alu_op_t;

  // Width and extension of the value returned by a load
  typedef enum logic [2:0] {
    ld_word   = 3'd0,
    ld_byte_s = 3'd1,
    ld_byte_u = 3'd2,
    ld_half_s = 3'd3,
    ld_half_u = 3'd4
  } load_kind_t;

endpackage

/* mips_defines.svh */
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// Address of the first instruction fetched after reset
`define MIPS_RESET_VECTOR 32'h0000_0000

`define MIPS_REG_COUNT 32 // General purpose registers, $0 included

`endif
